/* Bender.yml */
package:
  name: load_store_unit

sources:
  - rtl/lsu_pkg.sv
  - rtl/lsu_req_gen.sv
  - rtl/lsu_rdata_align.sv
  - rtl/lsu_ctrl.sv
  - rtl/load_store_unit.sv
  - target: test
    files:
      - dv/lsu_checker.sv
      - dv/tb_load_store_unit.sv

/* dv/lsu_checker.sv */
////////////////////
// lsu checker
// watches the DUT ports, checks bus requests and load results
////////////////////

`timescale 1ns/10ps

module lsu_checker #(
  parameter int unsigned DEPTH = 2
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      data_req_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0]  data_addr_o,
  input  logic                      data_we_o,
  input  logic [lsu_pkg::BE_W-1:0]  data_be_o,
  input  logic [lsu_pkg::XLEN-1:0]  data_wdata_o,
  input  logic                      req_ex_i,
  input  logic                      we_ex_i,
  input  lsu_pkg::data_type_e       type_ex_i,
  input  lsu_pkg::sign_ext_e        sign_ext_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]  wdata_ex_i,
  input  logic [1:0]                reg_offset_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]  operand_a_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]  operand_b_ex_i,
  input  logic                      addr_useincr_ex_i,
  input  logic                      misaligned_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]  rdata_ex_o,
  input  logic                      misaligned_o,
  input  logic                      ready_ex_o,
  input  logic                      ready_wb_o,
  input  logic                      busy_o,
  output int                        errors_o,
  output int                        outstanding_o
);

  import lsu_pkg::*;

  logic [7:0]  ref_mem [0:255];   // reference copy of the bus memory
  logic [31:0] exp_q [$];         // expected load result per transfer
  int          kind_q [$];        // test index, -1 for no check
  int          checks [5];
  int          fails [5];
  logic        stall_q;           // req without gnt last cycle
  logic        held_acc;          // current ex access already granted
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [3:0]  be_q;
  logic        we_q;

  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a * 29) ^ 8'ha7;  // odd multiplier, unique per address
  endfunction

  // zero, one or sign fill above the loaded bytes
  function automatic logic [31:0] extend_load(input logic [31:0] raw, input int size,
                                              input logic [1:0] mode);
    logic        fill;
    logic [31:0] v;
    v = raw;
    if (mode == 2'b00) fill = 1'b0;
    else if (mode == 2'b10) fill = 1'b1;
    else fill = raw[8*size-1];
    for (int i = 8 * size; i < 32; i++) v[i] = fill;
    return v;
  endfunction

  task automatic check(input int t, input logic ok, input string msg);
    checks[t]++;
    if (!ok) begin
      fails[t]++;
      errors_o++;
      $display("Fail %0t: %s", $time, msg);
    end
  endtask

  initial begin
    errors_o      = 0;
    outstanding_o = 0;
    stall_q       = 1'b0;
    held_acc      = 1'b0;
    for (int i = 0; i < 256; i++) ref_mem[i] = fill_byte(i);
    for (int i = 0; i < 5; i++) begin
      checks[i] = 0;
      fails[i]  = 0;
    end
  end

  always @(negedge clk) begin : watch
    int          size, lsb, k, t, base;
    logic [31:0] ea, raw;
    logic [7:0]  b;
    logic        split, en;
    logic [3:0]  be_exp;
    if (rst_n) begin
      ////////////////////
      // idle and ready rules
      if (!req_ex_i) check(4, ready_ex_o, "ready_ex_o low with no request");
      if (!req_ex_i && outstanding_o == 0)
        check(4, !busy_o && ready_wb_o, "busy_o or ready_wb_o wrong when idle");
      // request must hold while not granted
      if (stall_q)
        check(3, data_req_o && data_addr_o == addr_q && data_be_o == be_q &&
              data_we_o == we_q && data_wdata_o == wdata_q, "request changed before gnt");
      stall_q = data_req_o && !data_gnt_i;
      addr_q  = data_addr_o;
      be_q    = data_be_o;
      we_q    = data_we_o;
      wdata_q = data_wdata_o;

      if (data_rvalid_i) begin
        if (kind_q.size() == 0) begin
          check(3, 1'b0, "rvalid with nothing outstanding");
        end else begin
          t = kind_q.pop_front();
          raw = exp_q.pop_front();
          if (t >= 0)
            check(t, rdata_ex_o == raw, $sformatf("load got %h exp %h", rdata_ex_o, raw));
        end
        outstanding_o--;
      end

      if (data_req_o && data_gnt_i) begin
        outstanding_o++;
        ea    = addr_useincr_ex_i ? operand_a_ex_i + operand_b_ex_i : operand_a_ex_i;
        size  = (type_ex_i == LSU_WORD) ? 4 : (type_ex_i == LSU_HALF) ? 2 : 1;
        lsb   = int'(ea[1:0]);
        split = !misaligned_ex_i && (lsb + size > 4);
        t     = (misaligned_ex_i || split) ? 2 : (we_ex_i ? 0 : 1);
        if (!misaligned_ex_i) check(2, misaligned_o == split, "misaligned_o wrong");
        check(t, data_addr_o == (misaligned_ex_i ? {ea[31:2], 2'b00} : ea), "bus address wrong");
        check(t, data_we_o == we_ex_i, "bus we wrong");
        for (int l = 0; l < 4; l++) begin
          k = misaligned_ex_i ? l + 4 - lsb : l - lsb;  // byte index inside the access
          en = (k >= 0) && (k < size);
          be_exp[l] = en;
          if (en && we_ex_i) begin
            b = wdata_ex_i[8*((k + int'(reg_offset_ex_i)) % 4) +: 8];
            check(t, data_wdata_o[8*l +: 8] == b, $sformatf("store lane %0d wrong", l));
            ref_mem[({ea[7:2], 2'b00} + l) & 255] = b;
          end
        end
        check(t, data_be_o == be_exp, $sformatf("be %b exp %b", data_be_o, be_exp));
        if (we_ex_i || split) begin
          kind_q.push_back(-1);
          exp_q.push_back('0);
        end else begin
          base = misaligned_ex_i ? int'(ea[7:0]) - 4 : int'(ea[7:0]);
          raw  = '0;
          for (int i = 0; i < size; i++) raw[8*i +: 8] = ref_mem[(base + i) & 255];
          kind_q.push_back(t);
          exp_q.push_back(extend_load(raw, size, sign_ext_ex_i));
        end
      end

      // ex advances once per granted access
      if (data_req_o && data_gnt_i)
        check(3, !held_acc, "access granted twice");
      if (req_ex_i && ready_ex_o) begin
        check(3, held_acc || (data_req_o && data_gnt_i), "ready_ex_o high before gnt");
        held_acc = 1'b0;
      end else if (data_req_o && data_gnt_i) begin
        held_acc = 1'b1;
      end

      check(3, outstanding_o <= DEPTH, "more than DEPTH transfers outstanding");
    end
  end

  task automatic report();
    string names [5] = '{"aligned stores", "aligned loads", "misaligned accesses",
                         "back-pressure", "idle and reset"};
    int total;
    total = 0;
    for (int i = 0; i < 5; i++) begin
      $display("%-20s checks %0d errors %0d", names[i], checks[i], fails[i]);
      total += checks[i];
    end
    $display("total checks %0d errors %0d", total, errors_o);
  endtask

endmodule

/* dv/tb_load_store_unit.sv */
////////////////////
// lsu testbench
// random execute-stage driver and req/gnt bus memory model
////////////////////

`timescale 1ns/10ps

module tb_load_store_unit;

  import lsu_pkg::*;

  localparam int unsigned DEPTH = 2;
  localparam int N_ACCESS = 400;
  localparam int WAIT_MAX = 100;  // cycles per wait loop

  logic clk, rst_n;
  logic data_req, data_gnt, data_rvalid, data_we, misaligned, ready_ex, ready_wb, busy;
  logic [31:0] data_addr, data_wdata, data_rdata, rdata_ex;
  logic [3:0]  data_be;
  logic req_ex, we_ex, useincr, mis_ex;
  data_type_e  type_ex;
  sign_ext_e   sext_ex;
  logic [31:0] wdata_ex, op_a, op_b;
  logic [1:0]  roff;
  int          errors, outstanding;
  logic [31:0] lfsr_q = 32'h0e70_abd6;

  logic [7:0]  mem [0:255];
  int          due_q [$];   // cycle when each response may return
  logic [31:0] rsp_q [$];
  int          cyc;

  always #50 clk = ~clk;

  load_store_unit #(.DEPTH(DEPTH)) DUT (
    .clk(clk), .rst_n(rst_n),
    .data_req_o(data_req), .data_gnt_i(data_gnt), .data_rvalid_i(data_rvalid),
    .data_addr_o(data_addr), .data_we_o(data_we), .data_be_o(data_be),
    .data_wdata_o(data_wdata), .data_rdata_i(data_rdata),
    .req_ex_i(req_ex), .we_ex_i(we_ex), .type_ex_i(type_ex), .sign_ext_ex_i(sext_ex),
    .wdata_ex_i(wdata_ex), .reg_offset_ex_i(roff), .operand_a_ex_i(op_a),
    .operand_b_ex_i(op_b), .addr_useincr_ex_i(useincr), .misaligned_ex_i(mis_ex),
    .rdata_ex_o(rdata_ex), .misaligned_o(misaligned), .ready_ex_o(ready_ex),
    .ready_wb_o(ready_wb), .busy_o(busy)
  );

  lsu_checker #(.DEPTH(DEPTH)) u_checker (
    .clk(clk), .rst_n(rst_n),
    .data_req_o(data_req), .data_gnt_i(data_gnt), .data_rvalid_i(data_rvalid),
    .data_addr_o(data_addr), .data_we_o(data_we), .data_be_o(data_be),
    .data_wdata_o(data_wdata), .req_ex_i(req_ex), .we_ex_i(we_ex), .type_ex_i(type_ex),
    .sign_ext_ex_i(sext_ex), .wdata_ex_i(wdata_ex), .reg_offset_ex_i(roff),
    .operand_a_ex_i(op_a), .operand_b_ex_i(op_b), .addr_useincr_ex_i(useincr),
    .misaligned_ex_i(mis_ex), .rdata_ex_o(rdata_ex), .misaligned_o(misaligned),
    .ready_ex_o(ready_ex), .ready_wb_o(ready_wb), .busy_o(busy),
    .errors_o(errors), .outstanding_o(outstanding)
  );

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  ////////////////////
  // bus model, observes at negedge, drives 10 ns after posedge
  always begin : bus
    logic [31:0] r, word;
    logic        gnt_n;
    int          base;
    gnt_n = 1'b0;
    @(negedge clk);
    if (rst_n) begin
      if (data_rvalid) begin
        void'(due_q.pop_front());
        void'(rsp_q.pop_front());
      end
      if (data_req && data_gnt) begin
        base = {data_addr[7:2], 2'b00};
        for (int l = 0; l < 4; l++) begin
          if (data_we && data_be[l]) mem[base + l] = data_wdata[8*l +: 8];
          word[8*l +: 8] = mem[base + l];
        end
        take_bits(2, r);
        due_q.push_back(cyc + 1 + int'(r) % 3);  // 1 to 3 cycles after grant
        rsp_q.push_back(data_we ? 32'h0 : word);
      end
      take_bits(2, r);
      gnt_n = (r[1:0] != 2'b00);
    end
    @(posedge clk);
    cyc++;
    #10;
    data_gnt = gnt_n;
    data_rvalid = (due_q.size() != 0) && (due_q[0] <= cyc);
    data_rdata  = data_rvalid ? rsp_q[0] : 32'h0;
  end

  // waits for ready_ex_o, split tells whether a second phase follows
  task automatic wait_ready(output bit ok, output logic split);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!ready_ex && n < WAIT_MAX);
    ok = ready_ex;
    split = misaligned;
    if (!ok) $display("timeout: ready_ex_o never rose at %0t", $time);
    @(posedge clk);
    #10;
  endtask

  task automatic run_accesses(input int n, output bit ok);
    logic [31:0] r;
    logic        split;
    ok = 1'b1;
    for (int i = 0; i < n && ok; i++) begin
      take_bits(3, r);
      if (r[2:0] == 3'b000) begin  // occasional idle gap
        take_bits(2, r);           // gap length 1 to 4 cycles
        req_ex = 1'b0;
        repeat (int'(r[1:0]) + 1) begin
          @(posedge clk);
          #10;
        end
      end
      take_bits(1, r);
      we_ex = r[0];
      take_bits(2, r);
      type_ex = data_type_e'(r[1:0]);
      take_bits(2, r);
      sext_ex = sign_ext_e'(r[1:0]);
      take_bits(8, r);
      op_a = r;
      take_bits(4, r);
      op_b = r;
      take_bits(1, r);
      useincr = r[0];
      take_bits(2, r);
      roff = r[1:0];
      take_bits(32, r);
      wdata_ex = r;
      req_ex = 1'b1;
      mis_ex = 1'b0;
      wait_ready(ok, split);
      if (ok && split) begin
        op_a = op_a + 32'd4;  // second phase at the next word
        mis_ex = 1'b1;
        wait_ready(ok, split);
      end
      mis_ex = 1'b0;
    end
    req_ex = 1'b0;
  endtask

  task automatic wait_drain(output bit ok);
    int n;
    n = 0;
    while (outstanding != 0 && n < WAIT_MAX) begin
      @(posedge clk);
      n++;
    end
    ok = (outstanding == 0);
    if (!ok) $display("timeout: responses still outstanding at %0t", $time);
  endtask

  initial begin
    bit ok;
    clk = 1'b0;
    rst_n = 1'b0;
    cyc = 0;
    data_gnt = 1'b0;
    data_rvalid = 1'b0;
    data_rdata = '0;
    req_ex = 1'b0;
    we_ex = 1'b0;
    type_ex = LSU_WORD;
    sext_ex = LSU_ZERO_EXT;
    wdata_ex = '0;
    roff = '0;
    op_a = '0;
    op_b = '0;
    useincr = 1'b0;
    mis_ex = 1'b0;
    for (int i = 0; i < 256; i++) mem[i] = 8'(i * 29) ^ 8'ha7;  // same fill as checker
    repeat (4) @(posedge clk);
    #10 rst_n = 1'b1;
    @(posedge clk);  // one idle cycle right after reset
    #10;
    run_accesses(N_ACCESS, ok);
    if (ok) wait_drain(ok);
    repeat (2) @(posedge clk);
    u_checker.report();
    if (ok && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
rtl/lsu_pkg.sv
rtl/lsu_req_gen.sv
rtl/lsu_rdata_align.sv
rtl/lsu_ctrl.sv
rtl/load_store_unit.sv
dv/lsu_checker.sv
dv/tb_load_store_unit.sv

/* rtl/load_store_unit.sv */
////////////////////
// load/store unit
// ex-stage requests onto a req/gnt data bus, aligned loads back
////////////////////

`timescale 1ns/10ps

module load_store_unit #(
  parameter int unsigned DEPTH = 2  // max outstanding bus transfers
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // data bus
  output logic                      data_req_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  output logic [lsu_pkg::XLEN-1:0]  data_addr_o,
  output logic                      data_we_o,
  output logic [lsu_pkg::BE_W-1:0]  data_be_o,
  output logic [lsu_pkg::XLEN-1:0]  data_wdata_o,
  input  logic [lsu_pkg::XLEN-1:0]  data_rdata_i,
  // execute stage
  input  logic                      req_ex_i,
  input  logic                      we_ex_i,
  input  lsu_pkg::data_type_e       type_ex_i,
  input  lsu_pkg::sign_ext_e        sign_ext_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]  wdata_ex_i,
  input  logic [1:0]                reg_offset_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]  operand_a_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]  operand_b_ex_i,
  input  logic                      addr_useincr_ex_i,
  input  logic                      misaligned_ex_i,  // second phase of a split access
  output logic [lsu_pkg::XLEN-1:0]  rdata_ex_o,
  output logic                      misaligned_o,     // first phase needs a second access
  output logic                      ready_ex_o,
  output logic                      ready_wb_o,
  output logic                      busy_o
);

  logic       ctrl_update;  // latch wb control
  logic [1:0] addr_lsb;     // byte offset of the effective address

  assign data_we_o = we_ex_i;  // request fields are stable while req_ex_i is held

  ////////////////////
  // control
  lsu_ctrl #(
    .DEPTH (DEPTH)
  ) u_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_ex_i      (req_ex_i),
    .gnt_i         (data_gnt_i),
    .rvalid_i      (data_rvalid_i),
    .data_req_o    (data_req_o),
    .ready_ex_o    (ready_ex_o),
    .ready_wb_o    (ready_wb_o),
    .ctrl_update_o (ctrl_update),
    .busy_o        (busy_o)
  );

  ////////////////////
  // request datapath
  lsu_req_gen u_req_gen (
    .type_ex_i       (type_ex_i),
    .we_ex_i         (we_ex_i),
    .misaligned_ex_i (misaligned_ex_i),
    .req_ex_i        (req_ex_i),
    .wdata_ex_i      (wdata_ex_i),
    .reg_offset_ex_i (reg_offset_ex_i),
    .operand_a_i     (operand_a_ex_i),
    .operand_b_i     (operand_b_ex_i),
    .addr_useincr_i  (addr_useincr_ex_i),
    .addr_o          (data_addr_o),
    .addr_lsb_o      (addr_lsb),
    .be_o            (data_be_o),
    .wdata_o         (data_wdata_o),
    .misaligned_o    (misaligned_o)
  );

  // response datapath
  lsu_rdata_align u_rdata_align (
    .clk                (clk),
    .rst_n              (rst_n),
    .ctrl_update_i      (ctrl_update),
    .type_ex_i          (type_ex_i),
    .sign_ext_ex_i      (sign_ext_ex_i),
    .we_ex_i            (we_ex_i),
    .addr_lsb_i         (addr_lsb),
    .rvalid_i           (data_rvalid_i),
    .rdata_i            (data_rdata_i),
    .misaligned_ex_i    (misaligned_ex_i),
    .misaligned_first_i (misaligned_o),
    .rdata_o            (rdata_ex_o)
  );

endmodule

/* rtl/lsu_ctrl.sv */
////////////////////
// lsu control
// outstanding count, bus request, ex/wb ready and busy
////////////////////

`timescale 1ns/10ps

module lsu_ctrl #(
  parameter int unsigned DEPTH = 2  // max outstanding transfers
) (
  input  logic clk,
  input  logic rst_n,
  input  logic req_ex_i,
  input  logic gnt_i,
  input  logic rvalid_i,
  output logic data_req_o,
  output logic ready_ex_o,
  output logic ready_wb_o,
  output logic ctrl_update_o,  // ex access moves to wb this cycle
  output logic busy_o
);

  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] MAX_CNT = CNT_W'(DEPTH);

  logic [CNT_W-1:0] cnt_q;  // transfers granted, response pending
  logic [CNT_W-1:0] cnt_d;
  logic             accept;

  // request only while there is room, no path from rvalid
  assign data_req_o = req_ex_i && (cnt_q < MAX_CNT);
  assign accept     = data_req_o && gnt_i;

  always_comb begin
    cnt_d = cnt_q;
    case ({accept, rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;  // none, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  ////////////////////
  // ready rules
  // ex and wb advance together once wb is occupied
  always_comb begin
    if (!req_ex_i) begin
      ready_ex_o = 1'b1;
    end else if (cnt_q == '0) begin
      ready_ex_o = accept;  // wb empty
    end else if (cnt_q == CNT_W'(1)) begin
      ready_ex_o = accept && rvalid_i;  // wb must drain as ex moves in
    end else begin
      ready_ex_o = rvalid_i;
    end
  end

  assign ready_wb_o    = (cnt_q == '0) ? 1'b1 : rvalid_i;
  assign ctrl_update_o = ready_ex_o && req_ex_i;
  assign busy_o        = (cnt_q != '0) || data_req_o;

endmodule

/* rtl/lsu_pkg.sv */
////////////////////
// lsu package
// shared access-size and extension encodings, datapath widths
////////////////////

package lsu_pkg;

  // datapath width, byte-lane logic assumes 32 bits
  localparam int unsigned XLEN = 32;
  localparam int unsigned BE_W = XLEN / 8;  // one enable per byte lane

  ////////////////////
  // access size from the execute stage
  // code 2'b11 is not named, decoders fold it into byte
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } data_type_e;

  ////////////////////
  // load extension mode
  // code 2'b11 is decoded as sign extension
  typedef enum logic [1:0] {
    LSU_ZERO_EXT = 2'b00,
    LSU_SIGN_EXT = 2'b01,
    LSU_ONE_EXT  = 2'b10
  } sign_ext_e;

endpackage

/* rtl/lsu_rdata_align.sv */
////////////////////
// lsu load data alignment
// writeback control regs, lane select, split-load stitching, extension
////////////////////

`timescale 1ns/10ps

module lsu_rdata_align (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ctrl_update_i,  // access moves ex -> wb
  input  lsu_pkg::data_type_e       type_ex_i,
  input  lsu_pkg::sign_ext_e        sign_ext_ex_i,
  input  logic                      we_ex_i,
  input  logic [1:0]                addr_lsb_i,
  input  logic                      rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0]  rdata_i,
  input  logic                      misaligned_ex_i,     // ex holds a second phase
  input  logic                      misaligned_first_i,  // ex holds a split first phase
  output logic [lsu_pkg::XLEN-1:0]  rdata_o
);

  import lsu_pkg::*;

  // writeback copy of the access control
  data_type_e      type_q;
  sign_ext_e       sign_ext_q;
  logic [1:0]      offset_q;
  logic            we_q;

  logic [XLEN-1:0] rdata_q;    // first-half word or last result
  logic [XLEN-1:0] word_ext;
  logic [15:0]     half_raw;
  logic [7:0]      byte_raw;
  logic            half_fill;  // bit used for the upper 16
  logic            byte_fill;  // bit used for the upper 24
  logic [XLEN-1:0] rdata_ext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      type_q     <= LSU_WORD;
      sign_ext_q <= LSU_ZERO_EXT;
      offset_q   <= 2'b00;
      we_q       <= 1'b0;
    end else if (ctrl_update_i) begin
      type_q     <= type_ex_i;
      sign_ext_q <= sign_ext_ex_i;
      offset_q   <= addr_lsb_i;
      we_q       <= we_ex_i;
    end
  end

  ////////////////////
  // lane selection
  // offsets that cross a word pull the low part from rdata_q
  always_comb begin
    case (offset_q)
      2'b00:   word_ext = rdata_i;
      2'b01:   word_ext = {rdata_i[7:0], rdata_q[31:8]};
      2'b10:   word_ext = {rdata_i[15:0], rdata_q[31:16]};
      default: word_ext = {rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    case (offset_q)
      2'b00:   half_raw = rdata_i[15:0];
      2'b01:   half_raw = rdata_i[23:8];
      2'b10:   half_raw = rdata_i[31:16];
      default: half_raw = {rdata_i[7:0], rdata_q[31:24]};  // stitched halfword
    endcase
  end

  always_comb begin
    case (offset_q)
      2'b00:   byte_raw = rdata_i[7:0];
      2'b01:   byte_raw = rdata_i[15:8];
      2'b10:   byte_raw = rdata_i[23:16];
      default: byte_raw = rdata_i[31:24];
    endcase
  end

  ////////////////////
  // extension
  always_comb begin
    case (sign_ext_q)
      LSU_ZERO_EXT: begin
        half_fill = 1'b0;
        byte_fill = 1'b0;
      end
      LSU_ONE_EXT: begin
        half_fill = 1'b1;
        byte_fill = 1'b1;
      end
      default: begin  // sign, also code 11
        half_fill = half_raw[15];
        byte_fill = byte_raw[7];
      end
    endcase
  end

  always_comb begin
    case (type_q)
      LSU_WORD: rdata_ext = word_ext;
      LSU_HALF: rdata_ext = {{16{half_fill}}, half_raw};
      default:  rdata_ext = {{24{byte_fill}}, byte_raw};
    endcase
  end

  // during a split load keep the raw bus word for stitching
  always_ff @(posedge clk) begin
    if (rvalid_i && !we_q) begin
      if (misaligned_ex_i || misaligned_first_i) begin
        rdata_q <= rdata_i;
      end else begin
        rdata_q <= rdata_ext;
      end
    end
  end

  assign rdata_o = rvalid_i ? rdata_ext : rdata_q;  // hold last result between responses

endmodule

/* rtl/lsu_req_gen.sv */
////////////////////
// lsu request generation
// address, split detection, byte enables and store lane rotation
////////////////////

`timescale 1ns/10ps

module lsu_req_gen (
  input  lsu_pkg::data_type_e        type_ex_i,
  input  logic                       we_ex_i,
  input  logic                       misaligned_ex_i,  // second phase of a split access
  input  logic                       req_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]   wdata_ex_i,
  input  logic [1:0]                 reg_offset_ex_i,  // byte offset inside the register
  input  logic [lsu_pkg::XLEN-1:0]   operand_a_i,
  input  logic [lsu_pkg::XLEN-1:0]   operand_b_i,
  input  logic                       addr_useincr_i,   // a + b when set, else a
  output logic [lsu_pkg::XLEN-1:0]   addr_o,
  output logic [1:0]                 addr_lsb_o,
  output logic [lsu_pkg::BE_W-1:0]   be_o,
  output logic [lsu_pkg::XLEN-1:0]   wdata_o,
  output logic                       misaligned_o
);

  import lsu_pkg::*;

  logic [XLEN-1:0] addr_int;      // unaligned effective address
  logic [1:0]      wdata_offset;  // rotation amount in bytes
  logic [XLEN-1:0] wdata_rot;

  assign addr_int   = addr_useincr_i ? (operand_a_i + operand_b_i) : operand_a_i;
  assign addr_lsb_o = addr_int[1:0];

  // second phase always starts at the next word boundary
  assign addr_o = misaligned_ex_i ? {addr_int[XLEN-1:2], 2'b00} : addr_int;

  ////////////////////
  // byte enables
  always_comb begin
    case (type_ex_i)
      LSU_WORD: begin
        if (!misaligned_ex_i) begin
          be_o = 4'b1111 << addr_int[1:0];  // upper lanes of the first word
        end else begin
          case (addr_int[1:0])
            2'b01:   be_o = 4'b0001;  // lanes spilled into the next word
            2'b10:   be_o = 4'b0011;
            2'b11:   be_o = 4'b0111;
            default: be_o = 4'b0000;  // aligned words never split
          endcase
        end
      end
      LSU_HALF: begin
        if (!misaligned_ex_i) begin
          case (addr_int[1:0])
            2'b00:   be_o = 4'b0011;
            2'b01:   be_o = 4'b0110;
            2'b10:   be_o = 4'b1100;
            default: be_o = 4'b1000;  // low byte only, rest goes in phase two
          endcase
        end else begin
          be_o = 4'b0001;  // high byte of a halfword at offset 3
        end
      end
      default: be_o = 4'b0001 << addr_int[1:0];  // byte, also code 11
    endcase
  end

  ////////////////////
  // store data rotation
  // shift by address offset minus register offset, mod 4
  assign wdata_offset = addr_int[1:0] - reg_offset_ex_i;

  always_comb begin
    case (wdata_offset)
      2'b00:   wdata_rot = wdata_ex_i;
      2'b01:   wdata_rot = {wdata_ex_i[23:0], wdata_ex_i[31:24]};
      2'b10:   wdata_rot = {wdata_ex_i[15:0], wdata_ex_i[31:16]};
      default: wdata_rot = {wdata_ex_i[7:0], wdata_ex_i[31:8]};
    endcase
  end

  assign wdata_o = we_ex_i ? wdata_rot : '0;  // keep write bus quiet on loads

  // first phase only, words off a word boundary and halfwords at offset 3
  always_comb begin
    misaligned_o = 1'b0;
    if (req_ex_i && !misaligned_ex_i) begin
      case (type_ex_i)
        LSU_WORD: misaligned_o = (addr_int[1:0] != 2'b00);
        LSU_HALF: misaligned_o = (addr_int[1:0] == 2'b11);
        default:  misaligned_o = 1'b0;  // bytes never cross a word
      endcase
    end
  end

endmodule
